// File: Bender.yml
package:
  name: tone_synth

sources:
  - logic/synth_types_pkg.sv
  - logic/synth_bus_pkg.sv
  - logic/ctrl_regs.sv
  - logic/note_select.sv
  - logic/pitch_lookup.sv
  - logic/tone_gen.sv
  - logic/tone_synth.sv
  - target: simulation
    files:
      - verif/tone_synth_assert.sv
      - verif/tone_synth_tb.sv

// File: logic/ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_regs (
	input wire a_clk,
	input wire reset_n,
	input wire synth_bus_pkg::wb_req_t wb_req,
	output synth_bus_pkg::wb_rsp_t wb_rsp,
	input wire synth_types_pkg::note_t note,
	output synth_bus_pkg::ctrl_t ctrl,
	output synth_types_pkg::note_t midi_note
);

	logic req;
	logic armed;		// cleared by ack, set again once stb drops
	logic ack;
	logic take;
	logic [7:0] rd_dat;

	assign req = wb_req.cyc && wb_req.stb;
	assign take = req && armed;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			ack <= 1'b0;
			armed <= 1'b1;
		end
		else if (take)
		begin
			ack <= 1'b1;
			armed <= 1'b0;
		end
		else
		begin
			ack <= 1'b0;
			if (!wb_req.stb)
				armed <= 1'b1;
		end
	end

	// write lands on the edge that raises ack
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			ctrl <= '0;		// adc mode, unmuted
			midi_note <= '0;
		end
		else if (take && wb_req.we)
		begin
			case (wb_req.adr)
				synth_bus_pkg::addr_ctrl: ctrl <= synth_bus_pkg::ctrl_t'(wb_req.dat[3:0]);
				synth_bus_pkg::addr_note: midi_note <= wb_req.dat[6:0];
				default: ;		// status and addr 3 ignore writes
			endcase
		end
	end

	// master holds adr through the ack cycle
	always_comb
	begin
		case (wb_req.adr)
			synth_bus_pkg::addr_ctrl: rd_dat = {4'b0000, ctrl};
			synth_bus_pkg::addr_note: rd_dat = {1'b0, midi_note};
			synth_bus_pkg::addr_status: rd_dat = {1'b0, note};
			default: rd_dat = 8'h00;
		endcase
	end

	assign wb_rsp = {ack, rd_dat};

endmodule

`default_nettype wire

// File: logic/note_select.sv
`timescale 1ns/100ps
`default_nettype none

module note_select #(
	parameter int ADC_WIDTH = 12
) (
	input wire a_clk,
	input wire reset_n,
	input wire [ADC_WIDTH-1:0] adc_sample,
	input wire adc_valid,
	input wire synth_bus_pkg::ctrl_t ctrl,
	input wire synth_types_pkg::note_t midi_note,
	output synth_types_pkg::note_t note
);

	synth_types_pkg::note_t adc_top;	// last strobed sample, top bits
	synth_types_pkg::note_t adc_now;
	synth_types_pkg::note_t offset;
	synth_types_pkg::note_t adc_note;

	// a fresh sample bypasses adc_top so it reaches note in one cycle
	assign adc_now = adc_valid ? adc_sample[ADC_WIDTH-1 -: 7] : adc_top;

	always_comb
	begin
		case (ctrl.octave_sel)
			2'b00: offset = 7'd24;
			2'b01: offset = 7'd36;
			2'b10: offset = 7'd60;
			default: offset = 7'd48;
		endcase
	end

	assign adc_note = adc_now + offset;	// wraps mod 128

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			adc_top <= '0;
		else if (adc_valid)
			adc_top <= adc_sample[ADC_WIDTH-1 -: 7];
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			note <= '0;
		else if (ctrl.midi_mode)
			note <= midi_note;
		else
			note <= adc_note;
	end

endmodule

`default_nettype wire

// File: logic/pitch_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module pitch_lookup (
	input wire a_clk,
	input wire reset_n,
	input wire synth_types_pkg::note_t note,
	output synth_types_pkg::pitch_t pitch
);

	synth_types_pkg::pitch_class_t pitch_class;
	synth_types_pkg::octave_t octave;
	synth_types_pkg::period_t base;
	synth_types_pkg::pitch_t next;

	assign pitch_class = synth_types_pkg::pitch_class_t'(note % 7'd12);
	assign octave = synth_types_pkg::octave_t'(note / 7'd12);
	assign base = synth_types_pkg::base_period[pitch_class];

	always_comb
	begin
		// octave 9 is the table itself, octave 10 halves it
		if (octave == 4'd10)
			next.half_period = base >> 1;
		else
			next.half_period = base << (4'd9 - octave);

		next.hex1 = synth_types_pkg::seg_blank;
		case (pitch_class)
			4'd0: next.hex0 = synth_types_pkg::seg_c;
			4'd1:
			begin
				next.hex0 = synth_types_pkg::seg_d;
				next.hex1 = synth_types_pkg::seg_b;
			end
			4'd2: next.hex0 = synth_types_pkg::seg_d;
			4'd3:
			begin
				next.hex0 = synth_types_pkg::seg_e;
				next.hex1 = synth_types_pkg::seg_b;
			end
			4'd4: next.hex0 = synth_types_pkg::seg_e;
			4'd5: next.hex0 = synth_types_pkg::seg_f;
			4'd6:
			begin
				next.hex0 = synth_types_pkg::seg_g;
				next.hex1 = synth_types_pkg::seg_b;
			end
			4'd7: next.hex0 = synth_types_pkg::seg_g;
			4'd8:
			begin
				next.hex0 = synth_types_pkg::seg_a;
				next.hex1 = synth_types_pkg::seg_b;
			end
			4'd9: next.hex0 = synth_types_pkg::seg_a;
			4'd10:
			begin
				next.hex0 = synth_types_pkg::seg_b;
				next.hex1 = synth_types_pkg::seg_b;
			end
			4'd11: next.hex0 = synth_types_pkg::seg_b;
			default: next.hex0 = synth_types_pkg::seg_blank;
		endcase
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			pitch.half_period <= '0;	// no tone until first lookup
			pitch.hex0 <= synth_types_pkg::seg_blank;
			pitch.hex1 <= synth_types_pkg::seg_blank;
		end
		else
			pitch <= next;
	end

endmodule

`default_nettype wire

// File: logic/synth_bus_pkg.sv
`default_nettype none

package synth_bus_pkg;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// same bit layout as the control register
	typedef struct packed {
		logic mute;				// bit 3
		synth_types_pkg::octave_sel_t octave_sel;	// bits 2:1
		logic midi_mode;			// bit 0
	} ctrl_t;

	localparam logic [1:0] addr_ctrl = 2'd0;
	localparam logic [1:0] addr_note = 2'd1;
	localparam logic [1:0] addr_status = 2'd2;

endpackage

`default_nettype wire

// File: logic/synth_types_pkg.sv
`default_nettype none

package synth_types_pkg;

	typedef logic [6:0] note_t;		// midi note number
	typedef logic [3:0] pitch_class_t;	// note mod 12
	typedef logic [3:0] octave_t;		// note / 12, 0 to 10
	typedef logic [18:0] period_t;		// half period in a_clk cycles
	typedef logic [6:0] seg_t;		// bit 0 is segment a
	typedef logic [1:0] octave_sel_t;

	typedef struct packed {
		period_t half_period;
		seg_t hex0;
		seg_t hex1;
	} pitch_t;

	// half periods for octave 9, starting at C
	localparam period_t base_period [0:11] = '{
		19'd734, 19'd693, 19'd654, 19'd617, 19'd582, 19'd550,
		19'd519, 19'd490, 19'd462, 19'd436, 19'd412, 19'd389
	};

	localparam seg_t seg_c = 7'b0111001;
	localparam seg_t seg_d = 7'b1011110;
	localparam seg_t seg_e = 7'b1111001;
	localparam seg_t seg_f = 7'b1110001;
	localparam seg_t seg_g = 7'b1111101;
	localparam seg_t seg_a = 7'b1110111;
	localparam seg_t seg_b = 7'b1111100;	// also the flat sign
	localparam seg_t seg_blank = 7'b0000000;

endpackage

`default_nettype wire

// File: logic/tone_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tone_gen (
	input wire a_clk,
	input wire reset_n,
	input wire synth_types_pkg::period_t half_period,
	input wire mute,
	output logic tone
);

	synth_types_pkg::period_t count;
	synth_types_pkg::period_t last_period;	// detects a retune
	logic reload;

	// zero period means nothing to play yet
	assign reload = mute || (half_period != last_period) || (half_period == '0);

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			last_period <= '0;
		else
			last_period <= half_period;
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			tone <= 1'b0;
			count <= '0;
		end
		else if (reload)
		begin
			tone <= 1'b0;			// restart low
			count <= half_period - 19'd1;
		end
		else if (count == '0)
		begin
			tone <= ~tone;
			count <= half_period - 19'd1;
		end
		else
			count <= count - 19'd1;
	end

endmodule

`default_nettype wire

// File: logic/tone_synth.sv
`timescale 1ns/100ps
`default_nettype none

module tone_synth #(
	parameter int ADC_WIDTH = 12
) (
	input wire a_clk,
	input wire reset_n,
	input wire synth_bus_pkg::wb_req_t wb_req,
	output synth_bus_pkg::wb_rsp_t wb_rsp,
	input wire [ADC_WIDTH-1:0] adc_sample,
	input wire adc_valid,
	output logic tone,
	output synth_types_pkg::note_t led,
	output synth_types_pkg::seg_t hex0,
	output synth_types_pkg::seg_t hex1
);

	synth_bus_pkg::ctrl_t ctrl;
	synth_types_pkg::note_t midi_note;
	synth_types_pkg::note_t note;
	synth_types_pkg::pitch_t pitch;

	assign led = note;
	assign hex0 = pitch.hex0;
	assign hex1 = pitch.hex1;

	ctrl_regs u_ctrl_regs (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.note(note),
		.ctrl(ctrl),
		.midi_note(midi_note)
	);

	note_select #(
		.ADC_WIDTH(ADC_WIDTH)
	) u_note_select (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.adc_sample(adc_sample),
		.adc_valid(adc_valid),
		.ctrl(ctrl),
		.midi_note(midi_note),
		.note(note)
	);

	pitch_lookup u_pitch_lookup (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.note(note),
		.pitch(pitch)
	);

	tone_gen u_tone_gen (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.half_period(pitch.half_period),
		.mute(ctrl.mute),
		.tone(tone)
	);

endmodule

`default_nettype wire

// File: tone_synth.f
logic/synth_types_pkg.sv
logic/synth_bus_pkg.sv
logic/ctrl_regs.sv
logic/note_select.sv
logic/pitch_lookup.sv
logic/tone_gen.sv
logic/tone_synth.sv
verif/tone_synth_assert.sv
verif/tone_synth_tb.sv

// File: verif/tone_synth_assert.sv
`timescale 1ns/100ps
`default_nettype none

module tone_synth_assert (
	input wire a_clk,
	input wire reset_n,
	input wire synth_bus_pkg::wb_req_t wb_req,
	input wire synth_bus_pkg::wb_rsp_t wb_rsp,
	input wire mute,
	input wire tone,
	input wire synth_types_pkg::note_t led
);

	int fail_count = 0;

	task automatic flag(input string msg);
		$error("%s", msg);
		fail_count++;
	endtask

	ack_after_req: assert property (@(posedge a_clk) disable iff (reset_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else flag("ack raised without a request in the cycle before");

	ack_one_cycle: assert property (@(posedge a_clk) disable iff (reset_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else flag("ack held for more than one cycle");

	// mute register lands one edge before tone is forced low
	tone_muted: assert property (@(posedge a_clk) disable iff (reset_n)
		mute |=> !tone)
		else flag("tone high while muted");

	status_is_led: assert property (@(posedge a_clk) disable iff (reset_n)
		(wb_rsp.ack && !wb_req.we && wb_req.adr == synth_bus_pkg::addr_status)
		|-> wb_rsp.dat == {1'b0, led})
		else flag("status read differs from led");

endmodule

bind tone_synth tone_synth_assert u_assert (
	.a_clk(a_clk),
	.reset_n(reset_n),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.mute(ctrl.mute),
	.tone(tone),
	.led(led)
);

`default_nettype wire

// File: verif/tone_synth_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tone_synth_tb;

	localparam int ADC_WIDTH = 12;
	localparam int clk_period = 100;
	localparam int longest_half = 734 << 2;	// C7, lowest note played
	localparam int test_cycles = 60 + 128 * 5 + 4 * 40 + 6 * (3 * longest_half + 10)
		+ 6 * 734 + 50;
	localparam int base_tab [12] = '{734, 693, 654, 617, 582, 550,
		519, 490, 462, 436, 412, 389};
	localparam int tone_notes [6] = '{84, 91, 100, 113, 120, 127};	// octaves 7 to 10

	logic a_clk;
	logic reset_n;
	synth_bus_pkg::wb_req_t wb_req;
	synth_bus_pkg::wb_rsp_t wb_rsp;
	logic [ADC_WIDTH-1:0] adc_sample;
	logic adc_valid;
	logic tone;
	synth_types_pkg::note_t led;
	synth_types_pkg::seg_t hex0;
	synth_types_pkg::seg_t hex1;
	int errors = 0;
	int test_errors = 0;
	int checks = 0;

	tone_synth #(
		.ADC_WIDTH(ADC_WIDTH)
	) u_tone_synth (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.adc_sample(adc_sample),
		.adc_valid(adc_valid),
		.tone(tone),
		.led(led),
		.hex0(hex0),
		.hex1(hex1)
	);

	initial
	begin
		a_clk = 1'b0;
		forever #(clk_period / 2) a_clk = ~a_clk;
	end

	task automatic tick(input int n);
		repeat (n) @(posedge a_clk);
		#10;
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			test_errors++;
			$display("Mismatch at %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// one classic cycle with stb held for hold cycles after ack
	task automatic wb_access(input bit we, input logic [1:0] adr, input logic [7:0] dat,
		input int hold, output logic [7:0] rd);
		int waited;
		waited = 0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		tick(1);
		while (!wb_rsp.ack && waited < 8)
		begin
			tick(1);
			waited++;
		end
		if (!wb_rsp.ack)
		begin
			errors++;
			test_errors++;
			$display("Wishbone access to address %0d at %0t got no ack", adr, $time);
		end
		rd = wb_rsp.dat;
		repeat (hold)
		begin
			tick(1);
			check(!wb_rsp.ack, "second ack while stb held");
		end
		wb_req = '0;
		tick(1);	// stb low for one edge
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		wb_access(1'b1, adr, dat, 0, unused);
	endtask

	function automatic int model_half(input int n);
		if (n / 12 == 10)
			return base_tab[n % 12] >> 1;
		return base_tab[n % 12] << (9 - n / 12);
	endfunction

	function automatic logic [6:0] model_hex0(input int n);
		case (n % 12)
			0: return synth_types_pkg::seg_c;
			1, 2: return synth_types_pkg::seg_d;
			3, 4: return synth_types_pkg::seg_e;
			5: return synth_types_pkg::seg_f;
			6, 7: return synth_types_pkg::seg_g;
			8, 9: return synth_types_pkg::seg_a;
			default: return synth_types_pkg::seg_b;
		endcase
	endfunction

	function automatic logic [6:0] model_hex1(input int n);
		case (n % 12)
			1, 3, 6, 8, 10: return synth_types_pkg::seg_b;	// flat names
			default: return synth_types_pkg::seg_blank;
		endcase
	endfunction

	function automatic int model_adc_note(input logic [ADC_WIDTH-1:0] s, input int sel);
		int offs [4] = '{24, 36, 60, 48};
		return (s[ADC_WIDTH-1 -: 7] + offs[sel]) % 128;
	endfunction

	// capped so a stuck tone cannot hang the run
	task automatic cycles_to_toggle(output int cycles);
		logic start;
		start = tone;
		cycles = 0;
		while (tone == start && cycles <= longest_half + 8)
		begin
			tick(1);
			cycles++;
		end
	endtask

	task automatic test_registers();
		logic [7:0] rd;
		check(!wb_rsp.ack && !tone && led == 0, "ack, tone or led not zero after reset");
		check(hex0 == synth_types_pkg::seg_blank && hex1 == synth_types_pkg::seg_blank,
			"display not blank after reset");
		tick(2);
		check(led == 24, $sformatf("led %0d after reset, expected 24", led));
		wb_write(synth_bus_pkg::addr_ctrl, 8'h0d);
		wb_access(1'b0, synth_bus_pkg::addr_ctrl, 8'h00, 2, rd);
		check(rd == 8'h0d, $sformatf("ctrl read %h, expected 0d", rd));
		wb_write(synth_bus_pkg::addr_note, 8'hc5);
		wb_access(1'b0, synth_bus_pkg::addr_note, 8'h00, 0, rd);
		check(rd == 8'h45, $sformatf("note read %h, expected 45", rd));
		wb_access(1'b0, synth_bus_pkg::addr_status, 8'h00, 0, rd);
		check(rd == 8'h45, $sformatf("status read %h, expected 45", rd));
		wb_write(synth_bus_pkg::addr_status, 8'h12);
		wb_access(1'b0, synth_bus_pkg::addr_status, 8'h00, 1, rd);
		check(rd == 8'h45, $sformatf("status read %h after a write to it", rd));
		wb_access(1'b0, 2'd3, 8'h00, 0, rd);
		check(rd == 8'h00, $sformatf("address 3 read %h, expected 00", rd));
		finish_test("registers");
	endtask

	task automatic test_midi_display();
		int n;
		wb_write(synth_bus_pkg::addr_ctrl, 8'h01);
		for (n = 0; n < 128; n++)
		begin
			wb_write(synth_bus_pkg::addr_note, 8'(n));
			tick(1);	// two cycles after ack
			check(led == n && hex0 == model_hex0(n) && hex1 == model_hex1(n),
				$sformatf("note %0d shows led %0d hex1 %h hex0 %h", n, led, hex1, hex0));
		end
		finish_test("midi display");
	endtask

	task automatic test_adc_mode();
		logic [ADC_WIDTH-1:0] s;
		int sel;
		int expected;
		for (sel = 0; sel < 4; sel++)
		begin
			wb_write(synth_bus_pkg::addr_ctrl, 8'(sel << 1));
			repeat (8)
			begin
				s = ADC_WIDTH'($urandom);
				adc_sample = s;
				adc_valid = 1'b1;
				tick(1);
				adc_valid = 1'b0;
				expected = model_adc_note(s, sel);
				check(led == expected, $sformatf("sample %h sel %0d gave led %0d, expected %0d",
					s, sel, led, expected));
				adc_sample = ~s;	// no strobe
				tick(2);
				check(led == expected, "led followed a sample without adc_valid");
			end
		end
		finish_test("adc mode");
	endtask

	task automatic test_tone_period();
		int n;
		int hp;
		int cycles;
		wb_write(synth_bus_pkg::addr_ctrl, 8'h01);
		foreach (tone_notes[i])
		begin
			n = tone_notes[i];
			hp = model_half(n);
			wb_write(synth_bus_pkg::addr_note, 8'(n));
			tick(2);	// past the reload
			cycles_to_toggle(cycles);
			repeat (2)
			begin
				cycles_to_toggle(cycles);
				check(cycles == hp, $sformatf("note %0d toggled after %0d cycles, expected %0d",
					n, cycles, hp));
			end
		end
		finish_test("tone period");
	endtask

	task automatic test_mute_retune();
		int hp;
		int cycles;
		bit high_seen;
		hp = model_half(110);
		high_seen = 0;
		wb_write(synth_bus_pkg::addr_note, 8'd110);
		wb_write(synth_bus_pkg::addr_ctrl, 8'h09);
		repeat (2 * hp)
		begin
			high_seen |= tone;
			tick(1);
		end
		check(!high_seen, "tone went high while muted");
		wb_write(synth_bus_pkg::addr_ctrl, 8'h01);
		check(!tone, "tone not low after unmute");
		cycles_to_toggle(cycles);	// last reload was on the ack edge
		check(cycles == hp - 1, $sformatf("first toggle after unmute at %0d cycles", cycles));
		cycles_to_toggle(cycles);
		check(cycles == hp, $sformatf("toggle after unmute at %0d cycles", cycles));
		cycles_to_toggle(cycles);	// tone high going into the retune
		check(cycles == hp && tone, $sformatf("toggle before retune at %0d cycles", cycles));
		hp = model_half(121);
		wb_write(synth_bus_pkg::addr_note, 8'd121);
		tick(2);	// note, pitch, then reload
		check(!tone, "tone not low after retune");
		cycles_to_toggle(cycles);
		check(cycles == hp, $sformatf("first toggle after retune at %0d cycles", cycles));
		finish_test("mute and retune");
	endtask

	initial
	begin
		int total;
		void'($urandom(32'h94a9));
		reset_n = 1'b1;
		wb_req = '0;
		adc_sample = '0;
		adc_valid = 1'b0;
		repeat (4) @(posedge a_clk);
		#10;
		reset_n = 1'b0;
		test_registers();
		test_midi_display();
		test_adc_mode();
		test_tone_period();
		test_mute_retune();
		total = errors + u_tone_synth.u_assert.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			u_tone_synth.u_assert.fail_count);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		#(2 * test_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			2 * test_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
